// File: Bender.yml
package:
  name: hazardUnit

sources:
  - isaPkg.sv
  - hazardPkg.sv
  - instrClassifier.sv
  - stageTracker.sv
  - stallDetector.sv
  - forwardSelector.sv
  - hazardUnit.sv
  - target: test
    files:
      - hazardUnitTb.sv

// File: forwardSelector.sv
module forwardSelector (
	input hazardPkg::instrClassE clsD,
	input hazardPkg::instrClassE clsE,
	input hazardPkg::instrClassE clsM,
	input hazardPkg::instrClassE clsW,
	input isaPkg::regIdxT rsD,
	input isaPkg::regIdxT rtD,
	input isaPkg::regIdxT rsE,
	input isaPkg::regIdxT rtE,
	input isaPkg::regIdxT dstE,
	input isaPkg::regIdxT dstM,
	input isaPkg::regIdxT dstW,
	output hazardPkg::fwdDSelE rsDSel,
	output hazardPkg::fwdDSelE rtDSel,
	output hazardPkg::fwdESelE rsESel,
	output hazardPkg::fwdESelE rtESel,
	output hazardPkg::fwdMSelE rtMSel
);

	logic rsDDemand;
	logic rtDDemand;
	logic rsEDemand;
	logic rtEDemand;
	logic luiE;
	logic pcE;
	logic aluM;
	logic luiM;
	logic pcM;
	logic writesW;

	assign rsDDemand = clsD inside {hazardPkg::clsBranch, hazardPkg::clsBranchLink,
		hazardPkg::clsJr, hazardPkg::clsJalr, hazardPkg::clsCalR, hazardPkg::clsCalI,
		hazardPkg::clsLoad, hazardPkg::clsStore};
	assign rtDDemand = clsD inside {hazardPkg::clsBranch, hazardPkg::clsCalR,
		hazardPkg::clsStore, hazardPkg::clsShift};
	assign rsEDemand = clsE inside {hazardPkg::clsCalR, hazardPkg::clsCalI,
		hazardPkg::clsLoad, hazardPkg::clsStore};
	assign rtEDemand = clsE inside {hazardPkg::clsCalR, hazardPkg::clsStore,
		hazardPkg::clsShift};

	// Producers by stage and the datapath source they offer
	assign luiE = clsE == hazardPkg::clsLui;
	assign pcE = clsE inside {hazardPkg::clsJal, hazardPkg::clsBranchLink, hazardPkg::clsJalr};
	assign aluM = clsM inside {hazardPkg::clsCalR, hazardPkg::clsCalI, hazardPkg::clsShift};
	assign luiM = clsM == hazardPkg::clsLui;
	assign pcM = clsM inside {hazardPkg::clsJal, hazardPkg::clsBranchLink, hazardPkg::clsJalr};
	assign writesW = clsW inside {hazardPkg::clsCalR, hazardPkg::clsCalI, hazardPkg::clsShift,
		hazardPkg::clsLui, hazardPkg::clsLoad, hazardPkg::clsJal, hazardPkg::clsJalr,
		hazardPkg::clsBranchLink};

	// Nearest stage wins
	function automatic hazardPkg::fwdDSelE selD(input logic demand, input isaPkg::regIdxT src);
		hazardPkg::fwdDSelE sel;
		sel = hazardPkg::fromRegFile;
		if (demand && src != '0) begin
			if (luiE && src == dstE) begin
				sel = hazardPkg::fromLuiE;
			end else if (pcE && src == dstE) begin
				sel = hazardPkg::fromPcE;
			end else if (aluM && src == dstM) begin
				sel = hazardPkg::fromAluM;
			end else if (luiM && src == dstM) begin
				sel = hazardPkg::fromLuiM;
			end else if (pcM && src == dstM) begin
				sel = hazardPkg::fromPcM;
			end else if (writesW && src == dstW) begin
				sel = hazardPkg::fromWbW;
			end
		end
		return sel;
	endfunction

	function automatic hazardPkg::fwdESelE selE(input logic demand, input isaPkg::regIdxT src);
		hazardPkg::fwdESelE sel;
		sel = hazardPkg::fromRegFileE;
		if (demand && src != '0) begin
			if (aluM && src == dstM) begin
				sel = hazardPkg::fromAluME;
			end else if (luiM && src == dstM) begin
				sel = hazardPkg::fromLuiME;
			end else if (pcM && src == dstM) begin
				sel = hazardPkg::fromPcME;
			end else if (writesW && src == dstW) begin
				sel = hazardPkg::fromWbWE;
			end
		end
		return sel;
	endfunction

	always_comb begin
		rsDSel = selD(rsDDemand, rsD);
		rtDSel = selD(rtDDemand, rtD);
		rsESel = selE(rsEDemand, rsE);
		rtESel = selE(rtEDemand, rtE);
	end

	// Store data caught up with any writer now in Memory, loads included
	assign rtMSel = (clsE == hazardPkg::clsStore && rtE != '0 && rtE == dstM) ?
		hazardPkg::fromMemStage : hazardPkg::fromPipe;

endmodule

// File: hazardPkg.sv
package hazardPkg;

	typedef enum logic [3:0] {
		clsNone,
		clsCalR,
		clsCalI,
		clsShift,
		clsLui,
		clsLoad,
		clsStore,
		clsBranch,
		clsJal,
		clsJr,
		clsJalr,
		clsBranchLink
	} instrClassE;

	// Operand sources seen by the branch comparator in Decode
	typedef enum logic [2:0] {
		fromRegFile = 3'd0,
		fromLuiE    = 3'd1,
		fromPcE     = 3'd2,
		fromAluM    = 3'd3,
		fromLuiM    = 3'd4,
		fromPcM     = 3'd5,
		fromWbW     = 3'd6
	} fwdDSelE;

	// Operand sources seen by the ALU in Execute
	typedef enum logic [2:0] {
		fromRegFileE = 3'd0,
		fromAluME    = 3'd1,
		fromLuiME    = 3'd2,
		fromPcME     = 3'd3,
		fromWbWE     = 3'd4
	} fwdESelE;

	// Store data into the data memory
	typedef enum logic {
		fromPipe,
		fromMemStage
	} fwdMSelE;

	localparam isaPkg::instrT Nop = '0;

endpackage

// File: hazardUnit.f
isaPkg.sv
hazardPkg.sv
instrClassifier.sv
stageTracker.sv
stallDetector.sv
forwardSelector.sv
hazardUnit.sv
hazardUnitTb.sv

// File: hazardUnit.sv
module hazardUnit (
	input logic clk,
	input logic arstN,
	input isaPkg::instrT instrD,
	input logic mdBusy,
	input logic mdStart,
	output logic stall,
	output hazardPkg::fwdDSelE rsDSel,
	output hazardPkg::fwdDSelE rtDSel,
	output hazardPkg::fwdESelE rsESel,
	output hazardPkg::fwdESelE rtESel,
	output hazardPkg::fwdMSelE rtMSel
);

	isaPkg::instrT instrE;
	isaPkg::instrT instrM;
	isaPkg::instrT instrW;

	hazardPkg::instrClassE clsD;
	hazardPkg::instrClassE clsE;
	hazardPkg::instrClassE clsM;
	hazardPkg::instrClassE clsW;

	isaPkg::regIdxT rsD;
	isaPkg::regIdxT rtD;
	isaPkg::regIdxT rsE;
	isaPkg::regIdxT rtE;
	isaPkg::regIdxT dstE;
	isaPkg::regIdxT dstM;
	isaPkg::regIdxT dstW;
	logic multDivD;

	stageTracker uStageTracker (
		.clk(clk),
		.arstN(arstN),
		.stall(stall),
		.instrD(instrD),
		.instrE(instrE),
		.instrM(instrM),
		.instrW(instrW)
	);

	// Decode needs sources and the HI/LO flag, later stages only what they produce
	instrClassifier uClassD (
		.instr(instrD),
		.cls(clsD),
		.rs(rsD),
		.rt(rtD),
		.dst(),
		.multDiv(multDivD)
	);

	instrClassifier uClassE (
		.instr(instrE),
		.cls(clsE),
		.rs(rsE),
		.rt(rtE),
		.dst(dstE),
		.multDiv()
	);

	instrClassifier uClassM (
		.instr(instrM),
		.cls(clsM),
		.rs(),
		.rt(),
		.dst(dstM),
		.multDiv()
	);

	instrClassifier uClassW (
		.instr(instrW),
		.cls(clsW),
		.rs(),
		.rt(),
		.dst(dstW),
		.multDiv()
	);

	stallDetector uStallDetector (
		.clsD(clsD),
		.clsE(clsE),
		.clsM(clsM),
		.rsD(rsD),
		.rtD(rtD),
		.dstE(dstE),
		.dstM(dstM),
		.multDivD(multDivD),
		.mdBusy(mdBusy),
		.mdStart(mdStart),
		.stall(stall)
	);

	forwardSelector uForwardSelector (
		.clsD(clsD),
		.clsE(clsE),
		.clsM(clsM),
		.clsW(clsW),
		.rsD(rsD),
		.rtD(rtD),
		.rsE(rsE),
		.rtE(rtE),
		.dstE(dstE),
		.dstM(dstM),
		.dstW(dstW),
		.rsDSel(rsDSel),
		.rtDSel(rtDSel),
		.rsESel(rsESel),
		.rtESel(rtESel),
		.rtMSel(rtMSel)
	);

endmodule

// File: hazardUnitTb.sv
module hazardUnitTb;

	localparam int ResetCycles = 16;
	localparam int TestCycles = 2000;
	localparam int SlackCycles = 50;
	localparam int TimeoutCycles = ResetCycles + TestCycles + SlackCycles;
	// Directed tests take well under a hundred cycles
	localparam int RandCycles = 1900;

	typedef struct packed {
		logic stall;
		hazardPkg::fwdDSelE rsD;
		hazardPkg::fwdDSelE rtD;
		hazardPkg::fwdESelE rsE;
		hazardPkg::fwdESelE rtE;
		hazardPkg::fwdMSelE rtM;
	} expectT;

	logic clk;
	logic arstN;
	isaPkg::instrT instrD;
	logic mdBusy;
	logic mdStart;
	logic stall;
	hazardPkg::fwdDSelE rsDSel;
	hazardPkg::fwdDSelE rtDSel;
	hazardPkg::fwdESelE rsESel;
	hazardPkg::fwdESelE rtESel;
	hazardPkg::fwdMSelE rtMSel;

	// Shadow copy of the Execute, Memory and Writeback stages
	isaPkg::instrT shE = '0;
	isaPkg::instrT shM = '0;
	isaPkg::instrT shW = '0;
	isaPkg::instrT pool[$];
	logic [31:0] rngState = 32'h52a9;
	expectT cmpExp;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int held = 0;
	int h0;

	hazardUnit DUT (
		.clk(clk),
		.arstN(arstN),
		.instrD(instrD),
		.mdBusy(mdBusy),
		.mdStart(mdStart),
		.stall(stall),
		.rsDSel(rsDSel),
		.rtDSel(rtDSel),
		.rsESel(rsESel),
		.rtESel(rtESel),
		.rtMSel(rtMSel)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic isaPkg::instrT rInstr(input logic [5:0] fn, input isaPkg::regIdxT rs,
		input isaPkg::regIdxT rt, input isaPkg::regIdxT rd);
		return {6'b0, rs, rt, rd, 5'b0, fn};
	endfunction

	function automatic isaPkg::instrT iInstr(input logic [5:0] op, input isaPkg::regIdxT rs,
		input isaPkg::regIdxT rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Decode from the raw field values of the MIPS encoding
	function automatic void decodeRef(input isaPkg::instrT instr,
		output hazardPkg::instrClassE cls, output isaPkg::regIdxT rs,
		output isaPkg::regIdxT rt, output isaPkg::regIdxT dst, output logic md);
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rtf;
		op = instr[31:26];
		fn = instr[5:0];
		rtf = instr[20:16];
		md = 1'b0;
		cls = hazardPkg::clsNone;
		if (op == 6'd0) begin
			if (fn inside {6'd0, 6'd2, 6'd3}) cls = hazardPkg::clsShift;
			else if (fn == 6'd8) cls = hazardPkg::clsJr;
			else if (fn == 6'd9) cls = hazardPkg::clsJalr;
			else if (fn inside {[6'd16:6'd19], [6'd24:6'd27]}) begin
				cls = hazardPkg::clsCalR;
				md = 1'b1;
			end else if (fn inside {6'd4, 6'd6, 6'd7, [6'd32:6'd39], 6'd42, 6'd43}) begin
				cls = hazardPkg::clsCalR;
			end
		end else if (op == 6'd1) begin
			if (rtf inside {5'd0, 5'd1}) cls = hazardPkg::clsBranch;
			else if (rtf inside {5'd16, 5'd17}) cls = hazardPkg::clsBranchLink;
		end else if (op == 6'd3) cls = hazardPkg::clsJal;
		else if (op inside {[6'd4:6'd7]}) cls = hazardPkg::clsBranch;
		else if (op inside {[6'd8:6'd14]}) cls = hazardPkg::clsCalI;
		else if (op == 6'd15) cls = hazardPkg::clsLui;
		else if (op inside {6'd32, 6'd33, 6'd35, 6'd36, 6'd37}) cls = hazardPkg::clsLoad;
		else if (op inside {6'd40, 6'd41, 6'd43}) cls = hazardPkg::clsStore;
		rs = instr[25:21];
		rt = (op == 6'd1) ? 5'd0 : rtf;
		case (cls)
			hazardPkg::clsCalR, hazardPkg::clsShift, hazardPkg::clsJalr: dst = instr[15:11];
			hazardPkg::clsCalI, hazardPkg::clsLui, hazardPkg::clsLoad: dst = rtf;
			hazardPkg::clsJal, hazardPkg::clsBranchLink: dst = 5'd31;
			default: dst = 5'd0;
		endcase
	endfunction

	function automatic expectT refModel(input isaPkg::instrT iD, input isaPkg::instrT iE,
		input isaPkg::instrT iM, input isaPkg::instrT iW, input logic busy, input logic start);
		hazardPkg::instrClassE cD, cE, cM, cW;
		isaPkg::regIdxT sD, tD, sE, tE, dD, dE, dM, dW, unused;
		logic mdD, mdX, late, hitSE, hitTE, hitSM, hitTM, useS, useT;
		expectT e;
		decodeRef(iD, cD, sD, tD, dD, mdD);
		decodeRef(iE, cE, sE, tE, dE, mdX);
		decodeRef(iM, cM, unused, unused, dM, mdX);
		decodeRef(iW, cW, unused, unused, dW, mdX);
		late = cE inside {hazardPkg::clsCalR, hazardPkg::clsCalI, hazardPkg::clsShift,
			hazardPkg::clsLoad};
		hitSE = sD != 0 && sD == dE;
		hitTE = tD != 0 && tD == dE;
		hitSM = sD != 0 && sD == dM;
		hitTM = tD != 0 && tD == dM;
		e.stall = mdD && (busy || start);
		if (cD inside {hazardPkg::clsBranch, hazardPkg::clsBranchLink}) begin
			e.stall |= (late && (hitSE || hitTE)) || (cM == hazardPkg::clsLoad && (hitSM || hitTM));
		end
		if (cD inside {hazardPkg::clsJr, hazardPkg::clsJalr}) begin
			e.stall |= (late && hitSE) || (cM == hazardPkg::clsLoad && hitSM);
		end
		if (cE == hazardPkg::clsLoad) begin
			useS = cD inside {hazardPkg::clsCalR, hazardPkg::clsCalI, hazardPkg::clsLoad,
				hazardPkg::clsStore};
			useT = cD inside {hazardPkg::clsCalR, hazardPkg::clsShift};
			e.stall |= (useS && hitSE) || (useT && hitTE);
		end
		useS = cD inside {hazardPkg::clsBranch, hazardPkg::clsBranchLink, hazardPkg::clsJr,
			hazardPkg::clsJalr, hazardPkg::clsCalR, hazardPkg::clsCalI, hazardPkg::clsLoad,
			hazardPkg::clsStore};
		useT = cD inside {hazardPkg::clsBranch, hazardPkg::clsCalR, hazardPkg::clsStore,
			hazardPkg::clsShift};
		e.rsD = fwdDRef(useS ? sD : 5'd0, cE, dE, cM, dM, dW);
		e.rtD = fwdDRef(useT ? tD : 5'd0, cE, dE, cM, dM, dW);
		useS = cE inside {hazardPkg::clsCalR, hazardPkg::clsCalI, hazardPkg::clsLoad,
			hazardPkg::clsStore};
		useT = cE inside {hazardPkg::clsCalR, hazardPkg::clsStore, hazardPkg::clsShift};
		e.rsE = fwdERef(useS ? sE : 5'd0, cM, dM, dW);
		e.rtE = fwdERef(useT ? tE : 5'd0, cM, dM, dW);
		e.rtM = (cE == hazardPkg::clsStore && tE != 0 && tE == dM) ?
			hazardPkg::fromMemStage : hazardPkg::fromPipe;
		return e;
	endfunction

	// A zero source means no demand
	function automatic hazardPkg::fwdDSelE fwdDRef(input isaPkg::regIdxT src,
		input hazardPkg::instrClassE cE, input isaPkg::regIdxT dE,
		input hazardPkg::instrClassE cM, input isaPkg::regIdxT dM, input isaPkg::regIdxT dW);
		if (src == 0) return hazardPkg::fromRegFile;
		if (src == dE && cE == hazardPkg::clsLui) return hazardPkg::fromLuiE;
		if (src == dE && cE inside {hazardPkg::clsJal, hazardPkg::clsBranchLink,
			hazardPkg::clsJalr}) return hazardPkg::fromPcE;
		if (src == dM) begin
			if (cM inside {hazardPkg::clsCalR, hazardPkg::clsCalI, hazardPkg::clsShift}) begin
				return hazardPkg::fromAluM;
			end
			if (cM == hazardPkg::clsLui) return hazardPkg::fromLuiM;
			if (cM inside {hazardPkg::clsJal, hazardPkg::clsBranchLink, hazardPkg::clsJalr}) begin
				return hazardPkg::fromPcM;
			end
		end
		if (src == dW) return hazardPkg::fromWbW;
		return hazardPkg::fromRegFile;
	endfunction

	function automatic hazardPkg::fwdESelE fwdERef(input isaPkg::regIdxT src,
		input hazardPkg::instrClassE cM, input isaPkg::regIdxT dM, input isaPkg::regIdxT dW);
		if (src == 0) return hazardPkg::fromRegFileE;
		if (src == dM) begin
			if (cM inside {hazardPkg::clsCalR, hazardPkg::clsCalI, hazardPkg::clsShift}) begin
				return hazardPkg::fromAluME;
			end
			if (cM == hazardPkg::clsLui) return hazardPkg::fromLuiME;
			if (cM inside {hazardPkg::clsJal, hazardPkg::clsBranchLink, hazardPkg::clsJalr}) begin
				return hazardPkg::fromPcME;
			end
		end
		if (src == dW) return hazardPkg::fromWbWE;
		return hazardPkg::fromRegFileE;
	endfunction

	task automatic checkStall(input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: stall got %0b expected %0b", $time, got, exp);
		end
	endtask

	task automatic checkFwdD(input string sig, input hazardPkg::fwdDSelE got,
		input hazardPkg::fwdDSelE exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %s expected %s", $time, sig, got.name(), exp.name());
		end
	endtask

	task automatic checkFwdE(input string sig, input hazardPkg::fwdESelE got,
		input hazardPkg::fwdESelE exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %s expected %s", $time, sig, got.name(), exp.name());
		end
	endtask

	task automatic checkFwdM(input string sig, input hazardPkg::fwdMSelE got,
		input hazardPkg::fwdMSelE exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %s expected %s", $time, sig, got.name(), exp.name());
		end
	endtask

	task automatic expectHeld(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("%s held Decode for %0d cycles instead of %0d", what, got, exp);
		end
	endtask

	// Advance the shadow stages over one rising edge
	task automatic stepShadow(output logic accepted);
		expectT e;
		e = refModel(instrD, shE, shM, shW, mdBusy, mdStart);
		shW = shM;
		shM = shE;
		shE = e.stall ? hazardPkg::Nop : instrD;
		accepted = !e.stall;
	endtask

	task automatic issue(input isaPkg::instrT instr, input logic busy = 1'b0,
		input logic start = 1'b0);
		logic acc;
		acc = 1'b0;
		while (!acc) begin
			@(posedge clk);
			stepShadow(acc);
		end
		instrD <= instr;
		mdBusy <= busy;
		mdStart <= start;
	endtask

	task automatic waitEdge(input logic busy, input logic start);
		logic acc;
		@(posedge clk);
		stepShadow(acc);
		if (acc) instrD <= hazardPkg::Nop;
		mdBusy <= busy;
		mdStart <= start;
	endtask

	task automatic buildPool();
		isaPkg::functE f;
		isaPkg::opcodeE o;
		isaPkg::regimmE r;
		pool.push_back('0);
		f = f.first();
		repeat (f.num()) begin
			pool.push_back({6'b0, 20'b0, f});
			f = f.next();
		end
		r = r.first();
		repeat (r.num()) begin
			pool.push_back({6'b000001, 5'b0, r, 16'b0});
			r = r.next();
		end
		o = o.first();
		repeat (o.num()) begin
			if (o != isaPkg::opSpecial && o != isaPkg::opRegimm) pool.push_back({o, 26'b0});
			o = o.next();
		end
	endtask

	// Register fields stay in 0..3 so hazards come often
	function automatic isaPkg::instrT randomInstr();
		int idx;
		logic [31:0] r;
		isaPkg::instrT t;
		idx = nextRand() % pool.size();
		r = nextRand();
		t = pool[idx];
		if (idx == 0) return t;
		if (t[31:26] == 6'b000001) return t | {6'b0, 3'b0, r[1:0], 5'b0, r[31:16]};
		if (t[31:26] == 6'b0) begin
			return t | {6'b0, 3'b0, r[1:0], 3'b0, r[3:2], 3'b0, r[5:4],
				r[10:6], 6'b0};
		end
		return t | {6'b0, 3'b0, r[1:0], 3'b0, r[3:2], r[31:16]};
	endfunction

	always @(negedge clk) begin
		if (arstN) begin
			if (stall) held++;
			cmpExp = refModel(instrD, shE, shM, shW, mdBusy, mdStart);
			checkStall(stall, cmpExp.stall);
			checkFwdD("rsDSel", rsDSel, cmpExp.rsD);
			checkFwdD("rtDSel", rtDSel, cmpExp.rtD);
			checkFwdE("rsESel", rsESel, cmpExp.rsE);
			checkFwdE("rtESel", rtESel, cmpExp.rtE);
			checkFwdM("rtMSel", rtMSel, cmpExp.rtM);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TimeoutCycles) begin
			$display("timeout: run did not finish within %0d cycles", TimeoutCycles);
			$display("checks %0d, errors %0d", checks, errors);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		instrD = '0;
		mdBusy = 1'b0;
		mdStart = 1'b0;
		buildPool();
		repeat (ResetCycles) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkStall(stall, 1'b0);
		checkFwdD("rsDSel", rsDSel, hazardPkg::fromRegFile);
		checkFwdE("rsESel", rsESel, hazardPkg::fromRegFileE);
		checkFwdM("rtMSel", rtMSel, hazardPkg::fromPipe);

		// Load-use
		issue(iInstr(isaPkg::opLw, 5'd0, 5'd2, 16'h4));
		h0 = held;
		issue(rInstr(isaPkg::fnAddu, 5'd2, 5'd2, 5'd3));
		issue(hazardPkg::Nop);
		expectHeld(held - h0, 1, "load-use");
		@(negedge clk);
		checkFwdE("rsESel", rsESel, hazardPkg::fromWbWE);

		// Branch operands
		issue(rInstr(isaPkg::fnAddu, 5'd2, 5'd3, 5'd1));
		issue(iInstr(isaPkg::opBeq, 5'd1, 5'd0, 16'h8));
		@(negedge clk);
		checkStall(stall, 1'b1);
		waitEdge(1'b0, 1'b0);
		@(negedge clk);
		checkStall(stall, 1'b0);
		checkFwdD("rsDSel", rsDSel, hazardPkg::fromAluM);
		issue(iInstr(isaPkg::opLw, 5'd0, 5'd1, 16'h0));
		issue(hazardPkg::Nop);
		issue(iInstr(isaPkg::opBeq, 5'd1, 5'd1, 16'h8));
		@(negedge clk);
		checkStall(stall, 1'b1);
		waitEdge(1'b0, 1'b0);
		@(negedge clk);
		checkFwdD("rtDSel", rtDSel, hazardPkg::fromWbW);

		// Nearest producer first
		issue(rInstr(isaPkg::fnAddu, 5'd2, 5'd3, 5'd1));
		issue(iInstr(isaPkg::opLui, 5'd0, 5'd1, 16'h1234));
		issue(iInstr(isaPkg::opBne, 5'd1, 5'd0, 16'h8));
		@(negedge clk);
		checkFwdD("rsDSel", rsDSel, hazardPkg::fromLuiE);
		issue({isaPkg::opJal, 26'h40});
		issue(rInstr(isaPkg::fnJr, 5'd31, 5'd0, 5'd0));
		@(negedge clk);
		checkFwdD("rsDSel", rsDSel, hazardPkg::fromPcE);
		issue(rInstr(isaPkg::fnJalr, 5'd3, 5'd0, 5'd5));
		issue(hazardPkg::Nop);
		issue(iInstr(isaPkg::opBeq, 5'd5, 5'd0, 16'h8));
		@(negedge clk);
		checkFwdD("rsDSel", rsDSel, hazardPkg::fromPcM);
		issue({isaPkg::opRegimm, 5'd2, isaPkg::rtBltzal, 16'h4});
		issue(rInstr(isaPkg::fnAddu, 5'd31, 5'd31, 5'd6));
		@(negedge clk);
		checkFwdD("rtDSel", rtDSel, hazardPkg::fromPcE);
		// ALU writer of $0 sits in Memory when the branch reads $0
		issue(rInstr(isaPkg::fnAddu, 5'd1, 5'd2, 5'd0));
		issue(hazardPkg::Nop);
		issue(iInstr(isaPkg::opBeq, 5'd0, 5'd0, 16'h8));
		@(negedge clk);
		checkFwdD("rsDSel", rsDSel, hazardPkg::fromRegFile);

		// Store data from Memory
		issue(rInstr(isaPkg::fnSubu, 5'd1, 5'd2, 5'd2));
		issue(iInstr(isaPkg::opSw, 5'd0, 5'd2, 16'h8));
		issue(hazardPkg::Nop);
		@(negedge clk);
		checkFwdM("rtMSel", rtMSel, hazardPkg::fromMemStage);

		// HI/LO access while the divider runs
		issue(hazardPkg::Nop);
		h0 = held;
		issue(rInstr(isaPkg::fnMfhi, 5'd0, 5'd0, 5'd4), 1'b0, 1'b1);
		waitEdge(1'b1, 1'b0);
		waitEdge(1'b1, 1'b0);
		waitEdge(1'b0, 1'b0);
		waitEdge(1'b0, 1'b0);
		expectHeld(held - h0, 3, "mfhi");

		for (int i = 0; i < RandCycles; i++) begin
			logic acc;
			logic [31:0] r;
			@(posedge clk);
			stepShadow(acc);
			if (acc) instrD <= randomInstr();
			r = nextRand();
			mdBusy <= r[1:0] == 2'b00;
			mdStart <= r[4:2] == 3'b000;
		end
		@(negedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: instrClassifier.sv
module instrClassifier (
	input isaPkg::instrT instr,
	output hazardPkg::instrClassE cls,
	output isaPkg::regIdxT rs,
	output isaPkg::regIdxT rt,
	output isaPkg::regIdxT dst,
	output logic multDiv
);

	isaPkg::opcodeE opcode;
	isaPkg::functE funct;
	isaPkg::regimmE regimm;
	isaPkg::regIdxT rtField;
	isaPkg::regIdxT rdField;

	assign opcode = isaPkg::opcodeE'(instr[isaPkg::OpMsb -: isaPkg::OpWidth]);
	assign funct = isaPkg::functE'(instr[isaPkg::FunctMsb -: isaPkg::FunctWidth]);
	assign rtField = instr[isaPkg::RtMsb -: isaPkg::RegIdxWidth];
	assign rdField = instr[isaPkg::RdMsb -: isaPkg::RegIdxWidth];
	assign regimm = isaPkg::regimmE'(rtField);

	assign rs = instr[isaPkg::RsMsb -: isaPkg::RegIdxWidth];
	// Regimm branches hold a condition code in rt, not a register
	assign rt = (opcode == isaPkg::opRegimm) ? '0 : rtField;

	always_comb begin
		cls = hazardPkg::clsNone;
		multDiv = 1'b0;
		case (opcode)
			isaPkg::opSpecial: begin
				case (funct)
					isaPkg::fnAdd, isaPkg::fnAddu, isaPkg::fnSub, isaPkg::fnSubu,
					isaPkg::fnAnd, isaPkg::fnOr, isaPkg::fnXor, isaPkg::fnNor,
					isaPkg::fnSlt, isaPkg::fnSltu,
					isaPkg::fnSllv, isaPkg::fnSrlv, isaPkg::fnSrav: begin
						cls = hazardPkg::clsCalR;
					end
					isaPkg::fnMult, isaPkg::fnMultu, isaPkg::fnDiv, isaPkg::fnDivu,
					isaPkg::fnMthi, isaPkg::fnMtlo, isaPkg::fnMfhi, isaPkg::fnMflo: begin
						cls = hazardPkg::clsCalR;
						multDiv = 1'b1;
					end
					// Immediate shifts read only rt
					isaPkg::fnSll, isaPkg::fnSrl, isaPkg::fnSra: begin
						cls = hazardPkg::clsShift;
					end
					isaPkg::fnJr: begin
						cls = hazardPkg::clsJr;
					end
					isaPkg::fnJalr: begin
						cls = hazardPkg::clsJalr;
					end
					default: begin
						cls = hazardPkg::clsNone;
					end
				endcase
			end
			isaPkg::opRegimm: begin
				case (regimm)
					isaPkg::rtBltz, isaPkg::rtBgez: begin
						cls = hazardPkg::clsBranch;
					end
					isaPkg::rtBltzal, isaPkg::rtBgezal: begin
						cls = hazardPkg::clsBranchLink;
					end
					default: begin
						cls = hazardPkg::clsNone;
					end
				endcase
			end
			isaPkg::opBeq, isaPkg::opBne, isaPkg::opBlez, isaPkg::opBgtz: begin
				cls = hazardPkg::clsBranch;
			end
			isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti, isaPkg::opSltiu,
			isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori: begin
				cls = hazardPkg::clsCalI;
			end
			isaPkg::opLui: begin
				cls = hazardPkg::clsLui;
			end
			isaPkg::opLb, isaPkg::opLh, isaPkg::opLw, isaPkg::opLbu, isaPkg::opLhu: begin
				cls = hazardPkg::clsLoad;
			end
			isaPkg::opSb, isaPkg::opSh, isaPkg::opSw: begin
				cls = hazardPkg::clsStore;
			end
			isaPkg::opJal: begin
				cls = hazardPkg::clsJal;
			end
			// Plain j neither reads nor writes a register
			isaPkg::opJ: begin
				cls = hazardPkg::clsNone;
			end
			default: begin
				cls = hazardPkg::clsNone;
			end
		endcase
	end

	always_comb begin
		case (cls)
			hazardPkg::clsCalR, hazardPkg::clsShift, hazardPkg::clsJalr: dst = rdField;
			hazardPkg::clsCalI, hazardPkg::clsLui, hazardPkg::clsLoad: dst = rtField;
			hazardPkg::clsJal, hazardPkg::clsBranchLink: dst = isaPkg::LinkReg;
			default: dst = '0;
		endcase
	end

endmodule

// File: isaPkg.sv
package isaPkg;

	// Field widths of the fixed 32-bit MIPS encoding
	localparam int InstrWidth = 32;
	localparam int OpWidth = 6;
	localparam int FunctWidth = 6;
	localparam int RegIdxWidth = 5;

	// Most significant bit of each instruction field
	localparam int OpMsb = 31;
	localparam int RsMsb = 25;
	localparam int RtMsb = 20;
	localparam int RdMsb = 15;
	localparam int FunctMsb = 5;

	typedef logic [InstrWidth-1:0] instrT;
	typedef logic [RegIdxWidth-1:0] regIdxT;

	typedef enum logic [OpWidth-1:0] {
		opSpecial = 6'b000000,
		opRegimm  = 6'b000001,
		opJ       = 6'b000010,
		opJal     = 6'b000011,
		opBeq     = 6'b000100,
		opBne     = 6'b000101,
		opBlez    = 6'b000110,
		opBgtz    = 6'b000111,
		opAddi    = 6'b001000,
		opAddiu   = 6'b001001,
		opSlti    = 6'b001010,
		opSltiu   = 6'b001011,
		opAndi    = 6'b001100,
		opOri     = 6'b001101,
		opXori    = 6'b001110,
		opLui     = 6'b001111,
		opLb      = 6'b100000,
		opLh      = 6'b100001,
		opLw      = 6'b100011,
		opLbu     = 6'b100100,
		opLhu     = 6'b100101,
		opSb      = 6'b101000,
		opSh      = 6'b101001,
		opSw      = 6'b101011
	} opcodeE;

	typedef enum logic [FunctWidth-1:0] {
		fnSll   = 6'b000000,
		fnSrl   = 6'b000010,
		fnSra   = 6'b000011,
		fnSllv  = 6'b000100,
		fnSrlv  = 6'b000110,
		fnSrav  = 6'b000111,
		fnJr    = 6'b001000,
		fnJalr  = 6'b001001,
		fnMfhi  = 6'b010000,
		fnMthi  = 6'b010001,
		fnMflo  = 6'b010010,
		fnMtlo  = 6'b010011,
		fnMult  = 6'b011000,
		fnMultu = 6'b011001,
		fnDiv   = 6'b011010,
		fnDivu  = 6'b011011,
		fnAdd   = 6'b100000,
		fnAddu  = 6'b100001,
		fnSub   = 6'b100010,
		fnSubu  = 6'b100011,
		fnAnd   = 6'b100100,
		fnOr    = 6'b100101,
		fnXor   = 6'b100110,
		fnNor   = 6'b100111,
		fnSlt   = 6'b101010,
		fnSltu  = 6'b101011
	} functE;

	// Condition codes in the rt field of regimm branches
	typedef enum logic [RegIdxWidth-1:0] {
		rtBltz   = 5'b00000,
		rtBgez   = 5'b00001,
		rtBltzal = 5'b10000,
		rtBgezal = 5'b10001
	} regimmE;

	localparam regIdxT LinkReg = 5'd31;

endpackage

// File: stageTracker.sv
module stageTracker (
	input logic clk,
	input logic arstN,
	input logic stall,
	input isaPkg::instrT instrD,
	output isaPkg::instrT instrE,
	output isaPkg::instrT instrM,
	output isaPkg::instrT instrW
);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			instrE <= '0;
			instrM <= '0;
			instrW <= '0;
		end else begin
			// Bubble into Execute while Decode is held
			if (stall) begin
				instrE <= '0;
			end else begin
				instrE <= instrD;
			end
			instrM <= instrE;
			instrW <= instrM;
		end
	end

endmodule

// File: stallDetector.sv
module stallDetector (
	input hazardPkg::instrClassE clsD,
	input hazardPkg::instrClassE clsE,
	input hazardPkg::instrClassE clsM,
	input isaPkg::regIdxT rsD,
	input isaPkg::regIdxT rtD,
	input isaPkg::regIdxT dstE,
	input isaPkg::regIdxT dstM,
	input logic multDivD,
	input logic mdBusy,
	input logic mdStart,
	output logic stall
);

	logic loadE;
	logic loadM;
	logic resultLateE;
	logic rsHitE;
	logic rtHitE;
	logic rsHitM;
	logic rtHitM;
	logic branchStall;
	logic jumpStall;
	logic loadUseStall;
	logic multDivStall;

	assign loadE = clsE == hazardPkg::clsLoad;
	assign loadM = clsM == hazardPkg::clsLoad;
	// Results a Decode comparator cannot take from Execute
	assign resultLateE = loadE || (clsE inside {hazardPkg::clsCalR, hazardPkg::clsCalI,
		hazardPkg::clsShift});

	assign rsHitE = rsD != '0 && rsD == dstE;
	assign rtHitE = rtD != '0 && rtD == dstE;
	assign rsHitM = rsD != '0 && rsD == dstM;
	assign rtHitM = rtD != '0 && rtD == dstM;

	// Linking branches read rs like any other branch
	assign branchStall = (clsD inside {hazardPkg::clsBranch, hazardPkg::clsBranchLink}) &&
		((resultLateE && (rsHitE || rtHitE)) || (loadM && (rsHitM || rtHitM)));

	assign jumpStall = (clsD inside {hazardPkg::clsJr, hazardPkg::clsJalr}) &&
		((resultLateE && rsHitE) || (loadM && rsHitM));

	always_comb begin
		loadUseStall = 1'b0;
		if (loadE) begin
			case (clsD)
				hazardPkg::clsCalR: loadUseStall = rsHitE || rtHitE;
				hazardPkg::clsCalI, hazardPkg::clsLoad, hazardPkg::clsStore: begin
					loadUseStall = rsHitE;
				end
				hazardPkg::clsShift: loadUseStall = rtHitE;
				default: loadUseStall = 1'b0;
			endcase
		end
	end

	// HI/LO access waits for the divider to drain
	assign multDivStall = multDivD && (mdBusy || mdStart);

	assign stall = branchStall || jumpStall || loadUseStall || multDivStall;

endmodule
